/* odrg_defs.svh */
// Width, register map and mode-word bit macros; include wherever these constants are needed
`ifndef ODRG_DEFS_SVH
`define ODRG_DEFS_SVH

// Bus widths
`define ODRG_ADDR_W 32
`define ODRG_DATA_W 32
`define ODRG_BE_W   4

// Register block address map
`define ODRG_REG_AW        3
`define ODRG_REG_MODE      3'd0
`define ODRG_REG_SP_STORE  3'd1
`define ODRG_REG_MISMATCH0 3'd2
`define ODRG_REG_MISMATCH1 3'd3
`define ODRG_REG_MISMATCH2 3'd4

// Bit positions inside the mode word
`define ODRG_MODE_SPLIT     0
`define ODRG_MODE_DELAY     1
`define ODRG_MODE_SETBACK   2
`define ODRG_MODE_RELOAD_SB 3
`define ODRG_MODE_FORCE     4

`endif

/* odrg_pkg.sv */
// Mode and payload types of the lockstep supervisor, imported by the RTL modules that use them
`include "odrg_defs.svh"

package odrg_pkg;

  // Redundancy mode of the three cores
  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } redundancy_mode_e;

  // One core's instruction fetch request
  typedef struct packed {
    logic                    instr_req;
    logic [`ODRG_ADDR_W-1:0] instr_addr;
  } fetch_payload_t;

  // One core's data request fields, voted only while the request is active
  typedef struct packed {
    logic [`ODRG_ADDR_W-1:0] add;
    logic                    wen;
    logic [`ODRG_DATA_W-1:0] wdata;
    logic [`ODRG_BE_W-1:0]   be;
  } data_payload_t;

  // Flags of the mode word that steer the FSM
  typedef struct packed {
    logic split;
    logic delay_resynch;
    logic setback;
    logic reload_setback;
  } mode_cfg_t;

endpackage

/* odrg_ctrl_if.sv */
// Configuration levels and event pulses between the register block and the mode FSM
`timescale 1ns/1ps

interface odrg_ctrl_if import odrg_pkg::*; ();

  // Levels from the register block
  mode_cfg_t  cfg;
  logic       force_resynch;
  logic       sp_store_nonzero;
  // High in the cycle where zero is written to the state-pointer store
  logic       sp_store_clear_wr;

  // Single-cycle pulses from the FSM
  logic       force_ack;
  logic [2:0] mismatch_inc;

  modport regs (
    output cfg,
    output force_resynch,
    output sp_store_nonzero,
    output sp_store_clear_wr,
    input  force_ack,
    input  mismatch_inc
  );

  modport fsm (
    input  cfg,
    input  force_resynch,
    input  sp_store_nonzero,
    input  sp_store_clear_wr,
    output force_ack,
    output mismatch_inc
  );

endinterface

/* tmr_voter.sv */
// Bitwise three-way majority voter over any packed payload type, with per-core error flags
`timescale 1ns/1ps

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t   a_i,
  input  payload_t   b_i,
  input  payload_t   c_i,
  output payload_t   majority_o,
  output logic [2:0] error_cba_o,
  output logic       multi_error_o
);

  logic [$bits(payload_t)-1:0] a_bits;
  logic [$bits(payload_t)-1:0] b_bits;
  logic [$bits(payload_t)-1:0] c_bits;
  logic [$bits(payload_t)-1:0] maj_bits;

  assign a_bits = a_i;
  assign b_bits = b_i;
  assign c_bits = c_i;

  // Each bit takes the value held by at least two cores
  assign maj_bits   = (a_bits & b_bits) | (a_bits & c_bits) | (b_bits & c_bits);
  assign majority_o = payload_t'(maj_bits);

  // Bit k flags core k deviating from the majority anywhere
  assign error_cba_o[0] = (a_bits != maj_bits);
  assign error_cba_o[1] = (b_bits != maj_bits);
  assign error_cba_o[2] = (c_bits != maj_bits);

  // Two or more deviating cores
  assign multi_error_o = (error_cba_o[0] & error_cba_o[1]) |
                         (error_cba_o[0] & error_cba_o[2]) |
                         (error_cba_o[1] & error_cba_o[2]);

endmodule

/* odrg_regs.sv */
// Register block with mode word, state-pointer store and mismatch counters on a plain strobe
`timescale 1ns/1ps
`include "odrg_defs.svh"

module odrg_regs import odrg_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reg_req_i,
  input  logic                    reg_we_i,
  input  logic [`ODRG_REG_AW-1:0] reg_addr_i,
  input  logic [`ODRG_DATA_W-1:0] reg_wdata_i,
  output logic [`ODRG_DATA_W-1:0] reg_rdata_o,
  odrg_ctrl_if.regs               ctrl
);

  mode_cfg_t                    cfg_q;
  logic                         force_q;
  logic [`ODRG_DATA_W-1:0]      sp_store_q;
  logic [2:0][`ODRG_DATA_W-1:0] mismatch_q;
  logic                         wr_en;

  assign wr_en = reg_req_i & reg_we_i;

  // Mode word; the force bit clears itself once the FSM takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      force_q <= 1'b0;
    end else if (wr_en && reg_addr_i == `ODRG_REG_MODE) begin
      cfg_q.split          <= reg_wdata_i[`ODRG_MODE_SPLIT];
      cfg_q.delay_resynch  <= reg_wdata_i[`ODRG_MODE_DELAY];
      cfg_q.setback        <= reg_wdata_i[`ODRG_MODE_SETBACK];
      cfg_q.reload_setback <= reg_wdata_i[`ODRG_MODE_RELOAD_SB];
      force_q              <= reg_wdata_i[`ODRG_MODE_FORCE];
    end else if (ctrl.force_ack) begin
      force_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sp_store_q <= '0;
    end else if (wr_en && reg_addr_i == `ODRG_REG_SP_STORE) begin
      sp_store_q <= reg_wdata_i;
    end
  end

  // Per-core counters, a write loads the value
  for (genvar i = 0; i < 3; i++) begin : gen_mismatch_cnt
    logic cnt_wr;

    assign cnt_wr = wr_en && (int'(reg_addr_i) == `ODRG_REG_MISMATCH0 + i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mismatch_q[i] <= '0;
      end else if (cnt_wr) begin
        mismatch_q[i] <= reg_wdata_i;
      end else if (ctrl.mismatch_inc[i]) begin
        mismatch_q[i] <= mismatch_q[i] + 1'b1;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      `ODRG_REG_MODE: begin
        reg_rdata_o[`ODRG_MODE_SPLIT]     = cfg_q.split;
        reg_rdata_o[`ODRG_MODE_DELAY]     = cfg_q.delay_resynch;
        reg_rdata_o[`ODRG_MODE_SETBACK]   = cfg_q.setback;
        reg_rdata_o[`ODRG_MODE_RELOAD_SB] = cfg_q.reload_setback;
        reg_rdata_o[`ODRG_MODE_FORCE]     = force_q;
      end
      `ODRG_REG_SP_STORE:  reg_rdata_o = sp_store_q;
      `ODRG_REG_MISMATCH0: reg_rdata_o = mismatch_q[0];
      `ODRG_REG_MISMATCH1: reg_rdata_o = mismatch_q[1];
      `ODRG_REG_MISMATCH2: reg_rdata_o = mismatch_q[2];
      default:             reg_rdata_o = '0;
    endcase
  end

  assign ctrl.cfg               = cfg_q;
  assign ctrl.force_resynch     = force_q;
  assign ctrl.sp_store_nonzero  = (sp_store_q != '0);
  assign ctrl.sp_store_clear_wr = wr_en && (reg_addr_i == `ODRG_REG_SP_STORE) &&
                                  (reg_wdata_i == '0);

endmodule

/* odrg_mode_fsm.sv */
// Redundancy mode FSM; decides resynchronization, setback pulses and mismatch counting
`timescale 1ns/1ps

module odrg_mode_fsm import odrg_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [2:0]       error_cba_i,
  input  logic             cores_synch_i,
  odrg_ctrl_if.fsm         ctrl,
  output redundancy_mode_e red_mode_o,
  output logic             setback_o
);

  redundancy_mode_e red_mode_d, red_mode_q;
  logic             setback_d, setback_q;
  logic             mismatch;
  logic             single_core;

  assign mismatch    = (error_cba_i != 3'b000);
  assign single_core = (error_cba_i == 3'b001) || (error_cba_i == 3'b010) ||
                       (error_cba_i == 3'b100);

  // Later checks override earlier ones
  always_comb begin
    red_mode_d        = red_mode_q;
    setback_d         = 1'b0;
    ctrl.force_ack    = 1'b0;
    ctrl.mismatch_inc = 3'b000;

    if (red_mode_q == TMR_RUN) begin
      ctrl.force_ack = ctrl.force_resynch;
      if (single_core) begin
        ctrl.mismatch_inc = error_cba_i;
      end
      if ((mismatch || ctrl.force_resynch) && !ctrl.cfg.delay_resynch) begin
        red_mode_d = TMR_UNLOAD;
      end
    end

    // Software has saved the state, reload it
    if (red_mode_q == TMR_UNLOAD && ctrl.sp_store_nonzero) begin
      red_mode_d = TMR_RELOAD;
      setback_d  = ctrl.cfg.setback;
    end

    if (red_mode_q == TMR_RELOAD) begin
      if (!ctrl.sp_store_nonzero) begin
        red_mode_d = TMR_RUN;
      end else if (mismatch && ctrl.cfg.setback && ctrl.cfg.reload_setback &&
                   !ctrl.sp_store_clear_wr) begin
        // Fault during reload restarts the cores again
        setback_d = 1'b1;
      end
    end

    if (red_mode_q == TMR_RUN && ctrl.cfg.split) begin
      red_mode_d = NON_TMR;
    end

    // Rejoin only once the cores report identical state
    if (red_mode_q == NON_TMR && cores_synch_i && !ctrl.cfg.split) begin
      red_mode_d = TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      red_mode_q <= TMR_RUN;
      setback_q  <= 1'b0;
    end else begin
      red_mode_q <= red_mode_d;
      setback_q  <= setback_d;
    end
  end

  assign red_mode_o = red_mode_q;
  assign setback_o  = setback_q;

endmodule

/* odrg_bus_mux.sv */
// Steers fetch and data buses between cores and interconnect for lockstep or split mode
`timescale 1ns/1ps
`include "odrg_defs.svh"

module odrg_bus_mux import odrg_pkg::*; (
  input  redundancy_mode_e              red_mode_i,
  input  fetch_payload_t                fetch_i,
  input  logic                          data_req_i,
  input  data_payload_t                 data_i,
  // Core side
  input  logic [2:0]                    core_instr_req_i,
  input  logic [2:0][`ODRG_ADDR_W-1:0]  core_instr_addr_i,
  output logic [2:0]                    core_instr_gnt_o,
  output logic [2:0][`ODRG_DATA_W-1:0]  core_instr_rdata_o,
  output logic [2:0]                    core_instr_rvalid_o,
  input  logic [2:0]                    core_data_req_i,
  input  logic [2:0][`ODRG_ADDR_W-1:0]  core_data_add_i,
  input  logic [2:0]                    core_data_wen_i,
  input  logic [2:0][`ODRG_DATA_W-1:0]  core_data_wdata_i,
  input  logic [2:0][`ODRG_BE_W-1:0]    core_data_be_i,
  output logic [2:0]                    core_data_gnt_o,
  output logic [2:0][`ODRG_DATA_W-1:0]  core_data_rdata_o,
  output logic [2:0]                    core_data_rvalid_o,
  // Interconnect side
  output logic [2:0]                    intc_instr_req_o,
  output logic [2:0][`ODRG_ADDR_W-1:0]  intc_instr_addr_o,
  input  logic [2:0]                    intc_instr_gnt_i,
  input  logic [2:0][`ODRG_DATA_W-1:0]  intc_instr_rdata_i,
  input  logic [2:0]                    intc_instr_rvalid_i,
  output logic [2:0]                    intc_data_req_o,
  output logic [2:0][`ODRG_ADDR_W-1:0]  intc_data_add_o,
  output logic [2:0]                    intc_data_wen_o,
  output logic [2:0][`ODRG_DATA_W-1:0]  intc_data_wdata_o,
  output logic [2:0][`ODRG_BE_W-1:0]    intc_data_be_o,
  input  logic [2:0]                    intc_data_gnt_i,
  input  logic [2:0][`ODRG_DATA_W-1:0]  intc_data_rdata_i,
  input  logic [2:0]                    intc_data_rvalid_i
);

  logic split;

  assign split = (red_mode_i == NON_TMR);

  always_comb begin
    // Address and data fields of lanes 1 and 2 pass through in every mode
    intc_instr_addr_o = core_instr_addr_i;
    intc_data_add_o   = core_data_add_i;
    intc_data_wen_o   = core_data_wen_i;
    intc_data_wdata_o = core_data_wdata_i;
    intc_data_be_o    = core_data_be_i;

    if (split) begin
      intc_instr_req_o    = core_instr_req_i;
      intc_data_req_o     = core_data_req_i;
      core_instr_gnt_o    = intc_instr_gnt_i;
      core_instr_rdata_o  = intc_instr_rdata_i;
      core_instr_rvalid_o = intc_instr_rvalid_i;
      core_data_gnt_o     = intc_data_gnt_i;
      core_data_rdata_o   = intc_data_rdata_i;
      core_data_rvalid_o  = intc_data_rvalid_i;
    end else begin
      // Lane 0 carries the voted request, lanes 1 and 2 stay silent
      intc_instr_req_o     = {2'b00, fetch_i.instr_req};
      intc_instr_addr_o[0] = fetch_i.instr_addr;
      intc_data_req_o      = {2'b00, data_req_i};
      intc_data_add_o[0]   = data_i.add;
      intc_data_wen_o[0]   = data_i.wen;
      intc_data_wdata_o[0] = data_i.wdata;
      intc_data_be_o[0]    = data_i.be;

      // Lane 0 responses go to all cores
      core_instr_gnt_o    = {3{intc_instr_gnt_i[0]}};
      core_instr_rdata_o  = {3{intc_instr_rdata_i[0]}};
      core_instr_rvalid_o = {3{intc_instr_rvalid_i[0]}};
      core_data_gnt_o     = {3{intc_data_gnt_i[0]}};
      core_data_rdata_o   = {3{intc_data_rdata_i[0]}};
      core_data_rvalid_o  = {3{intc_data_rvalid_i[0]}};
    end
  end

endmodule

/* odrg_unit.sv */
// Top of the triple-core lockstep supervisor; place between three cores and the interconnect
`timescale 1ns/1ps
`include "odrg_defs.svh"

module odrg_unit import odrg_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Register access
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  logic [`ODRG_REG_AW-1:0]       reg_addr_i,
  input  logic [`ODRG_DATA_W-1:0]       reg_wdata_i,
  output logic [`ODRG_DATA_W-1:0]       reg_rdata_o,
  // Status
  output logic                          single_mismatch_o,
  output logic                          triple_mismatch_o,
  output logic [2:0]                    core_error_o,
  output logic                          resynch_req_o,
  input  logic                          cores_synch_i,
  output logic [2:0]                    core_setback_o,
  // Core side
  input  logic [2:0]                    core_instr_req_i,
  input  logic [2:0][`ODRG_ADDR_W-1:0]  core_instr_addr_i,
  output logic [2:0]                    core_instr_gnt_o,
  output logic [2:0][`ODRG_DATA_W-1:0]  core_instr_rdata_o,
  output logic [2:0]                    core_instr_rvalid_o,
  input  logic [2:0]                    core_data_req_i,
  input  logic [2:0][`ODRG_ADDR_W-1:0]  core_data_add_i,
  input  logic [2:0]                    core_data_wen_i,
  input  logic [2:0][`ODRG_DATA_W-1:0]  core_data_wdata_i,
  input  logic [2:0][`ODRG_BE_W-1:0]    core_data_be_i,
  output logic [2:0]                    core_data_gnt_o,
  output logic [2:0][`ODRG_DATA_W-1:0]  core_data_rdata_o,
  output logic [2:0]                    core_data_rvalid_o,
  // Interconnect side
  output logic [2:0]                    intc_instr_req_o,
  output logic [2:0][`ODRG_ADDR_W-1:0]  intc_instr_addr_o,
  input  logic [2:0]                    intc_instr_gnt_i,
  input  logic [2:0][`ODRG_DATA_W-1:0]  intc_instr_rdata_i,
  input  logic [2:0]                    intc_instr_rvalid_i,
  output logic [2:0]                    intc_data_req_o,
  output logic [2:0][`ODRG_ADDR_W-1:0]  intc_data_add_o,
  output logic [2:0]                    intc_data_wen_o,
  output logic [2:0][`ODRG_DATA_W-1:0]  intc_data_wdata_o,
  output logic [2:0][`ODRG_BE_W-1:0]    intc_data_be_o,
  input  logic [2:0]                    intc_data_gnt_i,
  input  logic [2:0][`ODRG_DATA_W-1:0]  intc_data_rdata_i,
  input  logic [2:0]                    intc_data_rvalid_i
);

  fetch_payload_t [2:0] fetch_in;
  data_payload_t  [2:0] data_in;
  fetch_payload_t       fetch_voted;
  data_payload_t        data_voted;
  logic                 data_req;
  logic [2:0]           main_error_cba;
  logic [2:0]           data_error_cba;
  logic                 main_multi;
  logic                 data_multi;
  redundancy_mode_e     red_mode;
  logic                 setback;

  odrg_ctrl_if ctrl_if ();

  for (genvar i = 0; i < 3; i++) begin : gen_payload
    assign fetch_in[i] = {core_instr_req_i[i], core_instr_addr_i[i]};
    assign data_in[i]  = {core_data_add_i[i], core_data_wen_i[i], core_data_wdata_i[i],
                          core_data_be_i[i]};
  end

  // The request strobe picks the majority and gates the data vote
  assign data_req = (core_data_req_i[0] & core_data_req_i[1]) |
                    (core_data_req_i[0] & core_data_req_i[2]) |
                    (core_data_req_i[1] & core_data_req_i[2]);

  tmr_voter #(
    .payload_t(fetch_payload_t)
  ) main_voter (
    .a_i          (fetch_in[0]),
    .b_i          (fetch_in[1]),
    .c_i          (fetch_in[2]),
    .majority_o   (fetch_voted),
    .error_cba_o  (main_error_cba),
    .multi_error_o(main_multi)
  );

  tmr_voter #(
    .payload_t(data_payload_t)
  ) data_voter (
    .a_i          (data_in[0]),
    .b_i          (data_in[1]),
    .c_i          (data_in[2]),
    .majority_o   (data_voted),
    .error_cba_o  (data_error_cba),
    .multi_error_o(data_multi)
  );

  // Data fields only matter while a data access is requested
  always_comb begin
    core_error_o      = main_error_cba;
    triple_mismatch_o = main_multi;
    if (data_req) begin
      core_error_o      = main_error_cba | data_error_cba;
      triple_mismatch_o = main_multi | data_multi;
    end
  end

  assign single_mismatch_o = (core_error_o != 3'b000);
  assign resynch_req_o     = single_mismatch_o && (red_mode == TMR_RUN);
  assign core_setback_o    = {3{setback}};

  odrg_regs i_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_req_i  (reg_req_i),
    .reg_we_i   (reg_we_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .ctrl       (ctrl_if)
  );

  odrg_mode_fsm i_mode_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .error_cba_i  (core_error_o),
    .cores_synch_i(cores_synch_i),
    .ctrl         (ctrl_if),
    .red_mode_o   (red_mode),
    .setback_o    (setback)
  );

  odrg_bus_mux i_bus_mux (
    .red_mode_i         (red_mode),
    .fetch_i            (fetch_voted),
    .data_req_i         (data_req),
    .data_i             (data_voted),
    .core_instr_req_i   (core_instr_req_i),
    .core_instr_addr_i  (core_instr_addr_i),
    .core_instr_gnt_o   (core_instr_gnt_o),
    .core_instr_rdata_o (core_instr_rdata_o),
    .core_instr_rvalid_o(core_instr_rvalid_o),
    .core_data_req_i    (core_data_req_i),
    .core_data_add_i    (core_data_add_i),
    .core_data_wen_i    (core_data_wen_i),
    .core_data_wdata_i  (core_data_wdata_i),
    .core_data_be_i     (core_data_be_i),
    .core_data_gnt_o    (core_data_gnt_o),
    .core_data_rdata_o  (core_data_rdata_o),
    .core_data_rvalid_o (core_data_rvalid_o),
    .intc_instr_req_o   (intc_instr_req_o),
    .intc_instr_addr_o  (intc_instr_addr_o),
    .intc_instr_gnt_i   (intc_instr_gnt_i),
    .intc_instr_rdata_i (intc_instr_rdata_i),
    .intc_instr_rvalid_i(intc_instr_rvalid_i),
    .intc_data_req_o    (intc_data_req_o),
    .intc_data_add_o    (intc_data_add_o),
    .intc_data_wen_o    (intc_data_wen_o),
    .intc_data_wdata_o  (intc_data_wdata_o),
    .intc_data_be_o     (intc_data_be_o),
    .intc_data_gnt_i    (intc_data_gnt_i),
    .intc_data_rdata_i  (intc_data_rdata_i),
    .intc_data_rvalid_i (intc_data_rvalid_i)
  );

endmodule

/* tb_odrg_tasks.svh */
// Check, wait, register access and directed test tasks; included inside the testbench module

task automatic fail_run(input string msg);
  $display("%s", msg);
  $display("RESULT: FAIL");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    fail_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected));
  end
endtask

task automatic reg_write(input logic [`ODRG_REG_AW-1:0] addr, input logic [31:0] data);
  @(negedge clk_i);
  reg_req_i   = 1'b1;
  reg_we_i    = 1'b1;
  reg_addr_i  = addr;
  reg_wdata_i = data;
  @(negedge clk_i);
  reg_req_i = 1'b0;
  reg_we_i  = 1'b0;
endtask

task automatic check_reg(input string name, input logic [`ODRG_REG_AW-1:0] addr,
                         input logic [31:0] expected);
  @(negedge clk_i);
  reg_req_i  = 1'b1;
  reg_we_i   = 1'b0;
  reg_addr_i = addr;
  #1;
  check_value(name, reg_rdata_o, expected);
  @(negedge clk_i);
  reg_req_i = 1'b0;
endtask

// All three cores issue the same fresh request
task automatic drive_cores(input logic data_req);
  exp_iaddr         = $random(seed);
  exp_daddr         = $random(seed);
  exp_wdata         = $random(seed);
  exp_be            = 4'($random(seed));
  exp_wen           = 1'($random(seed));
  core_instr_req_i  = 3'b111;
  core_instr_addr_i = {3{exp_iaddr}};
  core_data_req_i   = {3{data_req}};
  core_data_add_i   = {3{exp_daddr}};
  core_data_wen_i   = {3{exp_wen}};
  core_data_wdata_i = {3{exp_wdata}};
  core_data_be_i    = {3{exp_be}};
endtask

// Every interconnect lane answers with its own read data
task automatic drive_responses(input logic [2:0] gnt, input logic [2:0] rvalid);
  intc_instr_gnt_i    = gnt;
  intc_instr_rvalid_i = rvalid;
  intc_data_gnt_i     = gnt;
  intc_data_rvalid_i  = rvalid;
  for (int k = 0; k < 3; k++) begin
    intc_instr_rdata_i[k] = $random(seed);
    intc_data_rdata_i[k]  = $random(seed);
  end
endtask

// Called at the sample point after a falling edge
task automatic wait_resynch(input logic level);
  int n;
  n = 0;
  while (resynch_req_o !== level) begin
    if (n == WAIT_LIMIT) begin
      fail_run("Timeout while waiting for resynch_req_o to change");
    end
    @(negedge clk_i);
    #1;
    n++;
  end
endtask

task automatic wait_setback();
  int n;
  n = 0;
  do begin
    @(negedge clk_i);
    #1;
    n++;
  end while (core_setback_o !== 3'b111 && n < WAIT_LIMIT);
  if (core_setback_o !== 3'b111) begin
    fail_run("Timeout while waiting for the setback pulse on all cores");
  end
endtask

// From TMR_UNLOAD through TMR_RELOAD; the clear reaches TMR_RUN one clock later
task automatic reload_and_rejoin();
  reg_write(`ODRG_REG_SP_STORE, 32'h0000_1000);
  reg_write(`ODRG_REG_SP_STORE, 32'h0);
  @(negedge clk_i);
endtask

task automatic lockstep_steering();
  check_reg("reg_rdata_o (MODE)", `ODRG_REG_MODE, 32'h0);
  check_reg("reg_rdata_o (SP_STORE)", `ODRG_REG_SP_STORE, 32'h0);
  check_reg("reg_rdata_o (MISMATCH0)", `ODRG_REG_MISMATCH0, 32'h0);
  check_reg("reg_rdata_o (MISMATCH1)", `ODRG_REG_MISMATCH1, 32'h0);
  check_reg("reg_rdata_o (MISMATCH2)", `ODRG_REG_MISMATCH2, 32'h0);
  @(negedge clk_i);
  drive_cores(1'b1);
  drive_responses(3'b001, 3'b001);
  #1;
  check_value("intc_instr_req_o", 32'(intc_instr_req_o), 32'h1);
  check_value("intc_data_req_o", 32'(intc_data_req_o), 32'h1);
  check_value("intc_instr_addr_o[0]", intc_instr_addr_o[0], exp_iaddr);
  check_value("intc_data_add_o[0]", intc_data_add_o[0], exp_daddr);
  check_value("intc_data_wdata_o[0]", intc_data_wdata_o[0], exp_wdata);
  check_value("intc_data_be_o[0]", 32'(intc_data_be_o[0]), 32'(exp_be));
  check_value("intc_data_wen_o[0]", 32'(intc_data_wen_o[0]), 32'(exp_wen));
  check_value("core_instr_gnt_o", 32'(core_instr_gnt_o), 32'h7);
  check_value("core_instr_rvalid_o", 32'(core_instr_rvalid_o), 32'h7);
  check_value("core_data_gnt_o", 32'(core_data_gnt_o), 32'h7);
  check_value("core_data_rvalid_o", 32'(core_data_rvalid_o), 32'h7);
  for (int k = 0; k < 3; k++) begin
    check_value($sformatf("core_instr_rdata_o[%0d]", k), core_instr_rdata_o[k],
                intc_instr_rdata_i[0]);
    check_value($sformatf("core_data_rdata_o[%0d]", k), core_data_rdata_o[k],
                intc_data_rdata_i[0]);
  end
  check_value("core_error_o", 32'(core_error_o), 32'h0);
  check_value("single_mismatch_o", 32'(single_mismatch_o), 32'h0);
  check_value("triple_mismatch_o", 32'(triple_mismatch_o), 32'h0);
  check_value("resynch_req_o", 32'(resynch_req_o), 32'h0);
endtask

task automatic single_core_fault();
  @(negedge clk_i);
  drive_cores(1'b1);
  core_data_wdata_i[1] = exp_wdata ^ 32'h0000_0100;
  #1;
  check_value("core_error_o", 32'(core_error_o), 32'h2);
  check_value("single_mismatch_o", 32'(single_mismatch_o), 32'h1);
  check_value("triple_mismatch_o", 32'(triple_mismatch_o), 32'h0);
  check_value("resynch_req_o", 32'(resynch_req_o), 32'h1);
  check_value("intc_data_wdata_o[0]", intc_data_wdata_o[0], exp_wdata);
  // Without a data request the write data is not voted
  @(negedge clk_i);
  core_data_req_i = 3'b000;
  #1;
  check_value("core_error_o", 32'(core_error_o), 32'h0);
  check_value("single_mismatch_o", 32'(single_mismatch_o), 32'h0);
  check_value("intc_data_req_o", 32'(intc_data_req_o), 32'h0);
  check_reg("reg_rdata_o (MISMATCH0)", `ODRG_REG_MISMATCH0, 32'h0);
  check_reg("reg_rdata_o (MISMATCH1)", `ODRG_REG_MISMATCH1, 32'h1);
  drive_cores(1'b0);
  reload_and_rejoin();
endtask

task automatic multiple_mismatch();
  @(negedge clk_i);
  drive_cores(1'b0);
  core_instr_addr_i[0] = exp_iaddr ^ 32'h0000_0001;
  core_instr_addr_i[2] = exp_iaddr ^ 32'h0000_0010;
  #1;
  check_value("triple_mismatch_o", 32'(triple_mismatch_o), 32'h1);
  check_value("core_error_o", 32'(core_error_o), 32'h5);
  check_value("intc_instr_addr_o[0]", intc_instr_addr_o[0], exp_iaddr);
  @(negedge clk_i);
  drive_cores(1'b0);
  check_reg("reg_rdata_o (MISMATCH0)", `ODRG_REG_MISMATCH0, 32'h0);
  check_reg("reg_rdata_o (MISMATCH1)", `ODRG_REG_MISMATCH1, 32'h1);
  check_reg("reg_rdata_o (MISMATCH2)", `ODRG_REG_MISMATCH2, 32'h0);
  reload_and_rejoin();
endtask

task automatic resynch_flow();
  reg_write(`ODRG_REG_MODE, 32'h1 << `ODRG_MODE_SETBACK);
  @(negedge clk_i);
  drive_cores(1'b0);
  core_instr_addr_i[0] = exp_iaddr ^ 32'h8000_0000;
  #1;
  check_value("resynch_req_o", 32'(resynch_req_o), 32'h1);
  // Leaving TMR_RUN hides the request while the fault persists
  wait_resynch(1'b0);
  @(negedge clk_i);
  drive_cores(1'b0);
  reg_write(`ODRG_REG_SP_STORE, 32'h0000_2000);
  wait_setback();
  @(negedge clk_i);
  #1;
  check_value("core_setback_o", 32'(core_setback_o), 32'h0);
  reg_write(`ODRG_REG_SP_STORE, 32'h0);
  core_instr_addr_i[2] = exp_iaddr ^ 32'h0000_0400;
  #1;
  wait_resynch(1'b1);
  @(negedge clk_i);
  drive_cores(1'b0);
  reg_write(`ODRG_REG_MODE, 32'h0);
  check_reg("reg_rdata_o (MISMATCH0)", `ODRG_REG_MISMATCH0, 32'h1);
  check_reg("reg_rdata_o (MISMATCH2)", `ODRG_REG_MISMATCH2, 32'h1);
  reload_and_rejoin();
endtask

task automatic split_and_rejoin();
  reg_write(`ODRG_REG_MODE, 32'h1 << `ODRG_MODE_SPLIT);
  @(negedge clk_i);
  core_instr_req_i = 3'b101;
  core_data_req_i  = 3'b011;
  for (int k = 0; k < 3; k++) begin
    core_instr_addr_i[k] = $random(seed);
    core_data_wdata_i[k] = $random(seed);
  end
  drive_responses(3'b110, 3'b010);
  #1;
  check_value("intc_instr_req_o", 32'(intc_instr_req_o), 32'h5);
  check_value("intc_data_req_o", 32'(intc_data_req_o), 32'h3);
  check_value("core_instr_gnt_o", 32'(core_instr_gnt_o), 32'h6);
  check_value("core_data_rvalid_o", 32'(core_data_rvalid_o), 32'h2);
  check_value("resynch_req_o", 32'(resynch_req_o), 32'h0);
  for (int k = 0; k < 3; k++) begin
    check_value($sformatf("intc_instr_addr_o[%0d]", k), intc_instr_addr_o[k],
                core_instr_addr_i[k]);
    check_value($sformatf("intc_data_wdata_o[%0d]", k), intc_data_wdata_o[k],
                core_data_wdata_i[k]);
    check_value($sformatf("core_instr_rdata_o[%0d]", k), core_instr_rdata_o[k],
                intc_instr_rdata_i[k]);
    check_value($sformatf("core_data_rdata_o[%0d]", k), core_data_rdata_o[k],
                intc_data_rdata_i[k]);
  end
  // Clearing split alone keeps every lane open until the cores report synch
  @(negedge clk_i);
  drive_cores(1'b1);
  reg_write(`ODRG_REG_MODE, 32'h0);
  #1;
  check_value("intc_instr_req_o", 32'(intc_instr_req_o), 32'h7);
  @(negedge clk_i);
  cores_synch_i = 1'b1;
  @(negedge clk_i);
  cores_synch_i = 1'b0;
  #1;
  check_value("intc_instr_req_o", 32'(intc_instr_req_o), 32'h1);
  check_value("intc_data_req_o", 32'(intc_data_req_o), 32'h1);
endtask

task automatic forced_resynch();
  @(negedge clk_i);
  drive_cores(1'b0);
  reg_write(`ODRG_REG_MODE, 32'h1 << `ODRG_MODE_FORCE);
  check_reg("reg_rdata_o (MODE)", `ODRG_REG_MODE, 32'h0);
  // Mode has left TMR_RUN, so a fault is seen but not requested
  @(negedge clk_i);
  core_instr_addr_i[1] = exp_iaddr ^ 32'h0000_0002;
  #1;
  check_value("single_mismatch_o", 32'(single_mismatch_o), 32'h1);
  check_value("resynch_req_o", 32'(resynch_req_o), 32'h0);
  @(negedge clk_i);
  drive_cores(1'b0);
  #1;
  check_value("resynch_req_o", 32'(resynch_req_o), 32'h0);
  reload_and_rejoin();
  core_instr_addr_i[1] = exp_iaddr ^ 32'h0000_0020;
  #1;
  wait_resynch(1'b1);
  @(negedge clk_i);
  drive_cores(1'b0);
  check_reg("reg_rdata_o (MISMATCH1)", `ODRG_REG_MISMATCH1, 32'h2);
endtask

/* tb_odrg_unit.sv */
// Testbench top for the lockstep supervisor; drives dut0 through the directed tests in sequence
`timescale 1ns/1ps
`include "odrg_defs.svh"

module tb_odrg_unit;

  localparam int WAIT_LIMIT = 20;

  logic                          clk_i;
  logic                          rst_ni;
  // Register access
  logic                          reg_req_i;
  logic                          reg_we_i;
  logic [`ODRG_REG_AW-1:0]       reg_addr_i;
  logic [`ODRG_DATA_W-1:0]       reg_wdata_i;
  logic [`ODRG_DATA_W-1:0]       reg_rdata_o;
  // Status
  logic                          single_mismatch_o;
  logic                          triple_mismatch_o;
  logic [2:0]                    core_error_o;
  logic                          resynch_req_o;
  logic                          cores_synch_i;
  logic [2:0]                    core_setback_o;
  // Core side
  logic [2:0]                    core_instr_req_i;
  logic [2:0][`ODRG_ADDR_W-1:0]  core_instr_addr_i;
  logic [2:0]                    core_instr_gnt_o;
  logic [2:0][`ODRG_DATA_W-1:0]  core_instr_rdata_o;
  logic [2:0]                    core_instr_rvalid_o;
  logic [2:0]                    core_data_req_i;
  logic [2:0][`ODRG_ADDR_W-1:0]  core_data_add_i;
  logic [2:0]                    core_data_wen_i;
  logic [2:0][`ODRG_DATA_W-1:0]  core_data_wdata_i;
  logic [2:0][`ODRG_BE_W-1:0]    core_data_be_i;
  logic [2:0]                    core_data_gnt_o;
  logic [2:0][`ODRG_DATA_W-1:0]  core_data_rdata_o;
  logic [2:0]                    core_data_rvalid_o;
  // Interconnect side
  logic [2:0]                    intc_instr_req_o;
  logic [2:0][`ODRG_ADDR_W-1:0]  intc_instr_addr_o;
  logic [2:0]                    intc_instr_gnt_i;
  logic [2:0][`ODRG_DATA_W-1:0]  intc_instr_rdata_i;
  logic [2:0]                    intc_instr_rvalid_i;
  logic [2:0]                    intc_data_req_o;
  logic [2:0][`ODRG_ADDR_W-1:0]  intc_data_add_o;
  logic [2:0]                    intc_data_wen_o;
  logic [2:0][`ODRG_DATA_W-1:0]  intc_data_wdata_o;
  logic [2:0][`ODRG_BE_W-1:0]    intc_data_be_o;
  logic [2:0]                    intc_data_gnt_i;
  logic [2:0][`ODRG_DATA_W-1:0]  intc_data_rdata_i;
  logic [2:0]                    intc_data_rvalid_i;

  // Request the three cores agree on, kept as the expected voted values
  logic [`ODRG_ADDR_W-1:0]       exp_iaddr;
  logic [`ODRG_ADDR_W-1:0]       exp_daddr;
  logic [`ODRG_DATA_W-1:0]       exp_wdata;
  logic [`ODRG_BE_W-1:0]         exp_be;
  logic                          exp_wen;
  integer                        seed;

  odrg_unit dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  `include "tb_odrg_tasks.svh"

  initial begin
    seed          = 32;
    rst_ni        = 1'b0;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    cores_synch_i = 1'b0;
    drive_cores(1'b0);
    drive_responses(3'b000, 3'b000);
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    lockstep_steering();
    single_core_fault();
    multiple_mismatch();
    resynch_flow();
    split_and_rejoin();
    forced_resynch();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* odrg_unit.f */
+incdir+.
odrg_pkg.sv
odrg_ctrl_if.sv
tmr_voter.sv
odrg_regs.sv
odrg_mode_fsm.sv
odrg_bus_mux.sv
odrg_unit.sv
tb_odrg_unit.sv

/* Makefile */
# Verilator build, run and lint for the lockstep supervisor
VERILATOR ?= verilator
TB_TOP    ?= tb_odrg_unit
RTL_TOP   ?= odrg_unit
FLIST     ?= odrg_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
LINTFLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# The simulator exits with a failing status when the testbench stops with $fatal
run: build
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
